// ==== dv/item_stim.txt ====
# W addr data prob count (hex), T ticks (hex), P x y pixels (decimal), F random filler spot
# C name mask addr0 addr1 addr2 bombs speed range (hex, mask bit i is slot i)
F
C reset 0 0 0 0 1 4 1
W 2a 0 ffffffff 1
W 31 0 ffffffff 1
W 47 0 ffffffff 1
C fill_slots 7 2a 31 47 1 4 1
W 50 0 ffffffff 1
C all_busy 7 2a 31 47 1 4 1
T 5
C before_expiry 7 2a 31 47 1 4 1
T 1
C after_expiry 0 0 0 0 1 4 1
W 33 2 ffffffff 1
W 34 0 0 1
W 35 0 ffffffff 1
C lost_writes 1 35 0 0 1 4 1
W 36 0 ffffffff 1
W 37 0 ffffffff 1
C refill 7 35 36 37 1 4 1
P 1027 135
C bomb_pickup 5 35 0 37 2 4 1
T 1
C stay_on_tile 5 35 0 37 2 4 1
P 980 140
C speed_pickup 4 0 0 37 2 8 1
P 1100 150
C range_pickup 0 0 0 0 2 8 2
P 70 80
W 14 0 ffffffff c
C speed_24 0 0 0 0 6 18 6
W 14 0 ffffffff 3
C speed_cap 0 0 0 0 7 1c 7
W 14 0 ffffffff 3
C speed_held 0 0 0 0 8 1c 8
W 14 0 ffffffff 6
C all_caps 0 0 0 0 9 1c 9
F
C final 0 0 0 0 9 1c 9

// ==== sim.f ====
verilog/bomb_pkg.sv
verilog/lfsr_rand.sv
verilog/item_generator.sv
verilog/power_up.sv
verilog/item_subsystem_top.sv
dv/item_props.sv
dv/tb_item_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the item subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_item_subsystem -f sim.f

out=$(./obj_dir/Vtb_item_subsystem)
echo "$out"

# Exit status follows the testbench verdict
echo "$out" | grep -qx "Everything OK"

// ==== dv/tb_item_subsystem.sv ====
`timescale 1ns/1ps

module tb_item_subsystem;

    localparam int    CLK_HALF      = 20;   // 40 ns period
    localparam int    RST_CYCLES    = 8;
    localparam int    DRIVE_DLY     = 2;    // Inputs change this long after posedge
    localparam int    TILE_PX       = 64;   // Matches the DUT default
    localparam int    CYCLES_PER_LN = 40;
    localparam string STIM_FILE     = "dv/item_stim.txt";

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    tick;
    bomb_pkg::map_write_t    map_wr;
    bomb_pkg::player_pos_t   player;
    bomb_pkg::prob_t         probability;
    bomb_pkg::item_status_t  items [bomb_pkg::NUM_ITEMS];
    bomb_pkg::player_stats_t stats;

    int   pass_cnt    = 0;
    int   fail_cnt    = 0;
    int   cycle_cnt   = 0;
    int   cycle_limit = 0;          // Zero until the stim file is sized
    logic used_tile [256];          // Written tiles that fillers avoid

    // Expected values of the current C line
    logic [2:0]          e_mask;
    bomb_pkg::map_addr_t e_addr [bomb_pkg::NUM_ITEMS];
    bomb_pkg::bombs_t    e_bombs;
    bomb_pkg::speed_t    e_speed;
    bomb_pkg::range_t    e_range;

    item_subsystem_top dut (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .map_wr      (map_wr),
        .player      (player),
        .probability (probability),
        .items       (items),
        .stats       (stats)
    );

    always #(CLK_HALF) clk = ~clk;

    // ------------------------------------------------------------------
    // Timeout
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Run stopped: stimulus still running after %0d cycles", cycle_cnt);
            $display("Something failed");
            $finish;
        end
    end

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DLY);
        end
    endtask

    // Strobe, then two quiet cycles so any pickup reaches the stats
    task automatic write_tiles(input bomb_pkg::map_addr_t addr,
                               input bomb_pkg::map_data_t data,
                               input bomb_pkg::prob_t prob, input int count);
        repeat (count) begin
            map_wr          = '{we: 1'b1, addr: addr, data: data};
            probability     = prob;
            step(1);
            map_wr.we = 1'b0;
            step(2);
        end
    endtask

    task automatic send_ticks(input int count);
        repeat (count) begin
            tick = 1'b1;
            step(1);
            tick = 1'b0;  // One quiet cycle between ticks
            step(1);
        end
    endtask

    task automatic place_filler();
        int col;
        int row;
        do begin
            col = $urandom % bomb_pkg::NUM_COL;
            row = $urandom % bomb_pkg::NUM_ROW;
        end while (used_tile[row * bomb_pkg::NUM_COL + col]);
        player.x = bomb_pkg::pos_x_t'(col * TILE_PX + $urandom % TILE_PX);
        player.y = bomb_pkg::pos_y_t'(row * TILE_PX + $urandom % TILE_PX);
        step(1);
    endtask

    // ------------------------------------------------------------------
    // Compare outputs with a C line
    // ------------------------------------------------------------------
    task automatic check_state(input logic [8*24-1:0] name);
        int errs;
        errs = 0;
        for (int i = 0; i < bomb_pkg::NUM_ITEMS; i++) begin
            if (items[i].active !== e_mask[i]) begin
                $display("error %0t ns: %0s slot %0d active is %0b, expected %0b",
                         $time, name, i, items[i].active, e_mask[i]);
                errs++;
            end
            if (e_mask[i] && items[i].addr !== e_addr[i]) begin  // Addr only means something when live
                $display("error %0t ns: %0s slot %0d addr is %h, expected %h",
                         $time, name, i, items[i].addr, e_addr[i]);
                errs++;
            end
        end
        if (stats.max_bombs !== e_bombs) begin
            $display("error %0t ns: %0s bombs is %0d, expected %0d",
                     $time, name, stats.max_bombs, e_bombs);
            errs++;
        end
        if (stats.speed !== e_speed) begin
            $display("error %0t ns: %0s speed is %0d, expected %0d",
                     $time, name, stats.speed, e_speed);
            errs++;
        end
        if (stats.range !== e_range) begin
            $display("error %0t ns: %0s range is %0d, expected %0d",
                     $time, name, stats.range, e_range);
            errs++;
        end
        if (errs == 0) begin
            pass_cnt++;
            $display("test %0s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %0s: %0d mismatches", name, errs);
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        int                  fd;
        int                  n;
        int                  lines;
        int                  w_count;
        int                  px;
        int                  py;
        logic [8*16-1:0]     op;
        logic [8*24-1:0]     name;
        logic [8*128-1:0]    text;
        bomb_pkg::map_addr_t w_addr;
        bomb_pkg::map_data_t w_data;
        bomb_pkg::prob_t     w_prob;

        void'($urandom(32'ha27a));
        rst         = 1'b1;
        tick        = 1'b0;
        map_wr      = '0;
        player      = '0;
        probability = '0;
        lines       = 0;
        for (int i = 0; i < 256; i++) begin
            used_tile[i] = 1'b0;
        end

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %0s", STIM_FILE);
            fail_cnt++;
        end else begin
            // Size the run for the timeout and note every tile a write uses
            while ($fscanf(fd, "%s", op) == 1) begin
                lines++;
                if (op == "W") begin
                    n = $fscanf(fd, "%h", w_addr);
                    used_tile[w_addr] = 1'b1;
                end
                n = $fgets(text, fd);               // Rest of the line
            end
            $fclose(fd);
            cycle_limit = RST_CYCLES + lines * CYCLES_PER_LN;
            fd = $fopen(STIM_FILE, "r");

            step(RST_CYCLES);
            rst = 1'b0;

            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    n = $fgets(text, fd);           // Comment line
                end else if (op == "W") begin
                    n = $fscanf(fd, "%h %h %h %h", w_addr, w_data, w_prob, w_count);
                    write_tiles(w_addr, w_data, w_prob, w_count);
                end else if (op == "T") begin
                    n = $fscanf(fd, "%h", w_count);
                    send_ticks(w_count);
                end else if (op == "P") begin
                    n = $fscanf(fd, "%d %d", px, py);
                    player.x = bomb_pkg::pos_x_t'(px);
                    player.y = bomb_pkg::pos_y_t'(py);
                    step(2);                        // Pickup, then stats update
                end else if (op == "F") begin
                    place_filler();
                end else if (op == "C") begin
                    n = $fscanf(fd, "%s %h %h %h %h %h %h %h", name, e_mask, e_addr[0],
                                e_addr[1], e_addr[2], e_bombs, e_speed, e_range);
                    check_state(name);
                end else begin
                    $display("Unknown command %0s in the stimulus file", op);
                    fail_cnt++;
                end
            end
            $fclose(fd);
        end

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/item_props.sv ====
`timescale 1ns/1ps

module item_props (
    input logic                          clk,
    input logic                          rst,
    input logic [bomb_pkg::NUM_ITEMS-1:0] pickup,
    input bomb_pkg::item_status_t        items [bomb_pkg::NUM_ITEMS],
    input bomb_pkg::player_stats_t       stats
);

    // Each pickup is a single-cycle pulse
    pickup_pulse_a: assert property (@(posedge clk) disable iff (rst)
        (pickup != '0) |=> ((pickup & $past(pickup)) == '0))
        else $error("pickup stayed high for more than one cycle");

    // Last step may overshoot the limit by less than one step
    stat_cap_a: assert property (@(posedge clk) disable iff (rst)
        (stats.speed <= bomb_pkg::SPEED_LIMIT + bomb_pkg::SPEED_STEP - 6'd1)
        && (stats.max_bombs <= bomb_pkg::BOMBS_LIMIT)
        && (stats.range <= bomb_pkg::RANGE_LIMIT))
        else $error("player statistic above its cap");

    // ------------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------------
    reset_idle_a: assert property (@(posedge clk)
        rst |=> (pickup == '0) && !items[0].active && !items[1].active
                && !items[2].active && (stats.speed == bomb_pkg::STAT_SPEED_INIT)
                && (stats.max_bombs == bomb_pkg::STAT_BOMBS_INIT)
                && (stats.range == bomb_pkg::STAT_RANGE_INIT))
        else $error("outputs not at reset values after reset");

endmodule

bind power_up item_props u_props (
    .clk    (clk),
    .rst    (rst),
    .pickup (pickup),
    .items  (items),
    .stats  (stats_q)
);

// ==== verilog/item_subsystem_top.sv ====
`timescale 1ns/1ps

module item_subsystem_top #(
    parameter int TILE_PX   = 64,   // Pixels per tile
    parameter int ITEM_TIME = 6     // Item lifetime in game ticks
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  bomb_pkg::map_write_t     map_wr,       // Freed-block write
    input  bomb_pkg::player_pos_t    player,
    input  bomb_pkg::prob_t          probability,
    output bomb_pkg::item_status_t   items [bomb_pkg::NUM_ITEMS],
    output bomb_pkg::player_stats_t  stats
);

    // ------------------------------------------------------------------
    // Power-up subsystem
    // ------------------------------------------------------------------
    power_up #(
        .TILE_PX   (TILE_PX),
        .ITEM_TIME (ITEM_TIME)
    ) u_power_up (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .map_wr      (map_wr),
        .player      (player),
        .probability (probability),
        .items       (items),
        .stats       (stats)
    );

endmodule

// ==== verilog/power_up.sv ====
`timescale 1ns/1ps

module power_up #(
    parameter int TILE_PX   = 64,
    parameter int ITEM_TIME = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  bomb_pkg::map_write_t     map_wr,
    input  bomb_pkg::player_pos_t    player,
    input  bomb_pkg::prob_t          probability,
    output bomb_pkg::item_status_t   items [bomb_pkg::NUM_ITEMS],
    output bomb_pkg::player_stats_t  stats
);

    bomb_pkg::item_kind_t    slot_q;                            // Next slot to get a write
    bomb_pkg::map_write_t    slot_wr [bomb_pkg::NUM_ITEMS];
    logic [bomb_pkg::NUM_ITEMS-1:0] pickup;
    bomb_pkg::prob_t         rand_val;                          // Shared draw
    bomb_pkg::player_stats_t stats_q;

    // ------------------------------------------------------------------
    // Round-robin slot index, advances on every write strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_q <= bomb_pkg::ITEM_SPEED;
        end else if (map_wr.we) begin
            if (slot_q == bomb_pkg::ITEM_RANGE) begin
                slot_q <= bomb_pkg::ITEM_SPEED;  // Wrap
            end else begin
                slot_q <= bomb_pkg::item_kind_t'(slot_q + 2'd1);
            end
        end
    end

    // Only the indexed slot sees we high
    always_comb begin
        for (int i = 0; i < bomb_pkg::NUM_ITEMS; i++) begin
            slot_wr[i]    = map_wr;
            slot_wr[i].we = map_wr.we && (slot_q == i);
        end
    end

    // ------------------------------------------------------------------
    // Player statistics, one step per pickup up to the cap
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            stats_q.max_bombs <= bomb_pkg::STAT_BOMBS_INIT;
            stats_q.speed     <= bomb_pkg::STAT_SPEED_INIT;
            stats_q.range     <= bomb_pkg::STAT_RANGE_INIT;
        end else begin
            if (pickup[bomb_pkg::ITEM_SPEED] && (stats_q.speed < bomb_pkg::SPEED_LIMIT)) begin
                stats_q.speed <= stats_q.speed + bomb_pkg::SPEED_STEP;
            end
            if (pickup[bomb_pkg::ITEM_BOMB] && (stats_q.max_bombs < bomb_pkg::BOMBS_LIMIT)) begin
                stats_q.max_bombs <= stats_q.max_bombs + 4'd1;
            end
            if (pickup[bomb_pkg::ITEM_RANGE] && (stats_q.range < bomb_pkg::RANGE_LIMIT)) begin
                stats_q.range <= stats_q.range + 4'd1;
            end
        end
    end

    assign stats = stats_q;

    // ------------------------------------------------------------------
    // Random source and the three slots
    // ------------------------------------------------------------------
    lfsr_rand u_rand (
        .clk      (clk),
        .rst      (rst),
        .rand_val (rand_val)
    );

    for (genvar g = 0; g < bomb_pkg::NUM_ITEMS; g++) begin : gen_slot
        // 0 speed up, 1 extra bomb, 2 bomb range
        item_generator #(
            .TILE_PX   (TILE_PX),
            .ITEM_TIME (ITEM_TIME)
        ) u_item (
            .clk         (clk),
            .rst         (rst),
            .tick        (tick),
            .wr          (slot_wr[g]),
            .player      (player),
            .probability (probability),
            .rand_val    (rand_val),
            .status      (items[g]),
            .pickup      (pickup[g])
        );
    end

endmodule

// ==== verilog/item_generator.sv ====
`timescale 1ns/1ps

module item_generator #(
    parameter int TILE_PX   = 64,
    parameter int ITEM_TIME = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tick,
    input  bomb_pkg::map_write_t     wr,
    input  bomb_pkg::player_pos_t    player,
    input  bomb_pkg::prob_t          probability,
    input  bomb_pkg::prob_t          rand_val,
    output bomb_pkg::item_status_t   status,
    output logic                     pickup
);

    localparam int TILE_SHIFT = $clog2(TILE_PX);      // TILE_PX is a power of two
    localparam int LIFE_W     = $clog2(ITEM_TIME + 1);

    bomb_pkg::item_state_t state_q;
    bomb_pkg::map_addr_t   addr_q;      // Tile the item sits on
    logic [LIFE_W-1:0]     life_q;      // Ticks left

    bomb_pkg::pos_x_t      player_col;
    bomb_pkg::pos_y_t      player_row;
    logic [15:0]           player_tile; // Wide enough for any pixel position
    logic                  on_map;
    logic                  on_item;
    logic                  spawn;

    // ------------------------------------------------------------------
    // Player pixel position to tile address
    // ------------------------------------------------------------------
    assign player_col  = player.x >> TILE_SHIFT;
    assign player_row  = player.y >> TILE_SHIFT;
    assign player_tile = 16'(player_row) * 16'(bomb_pkg::NUM_COL) + 16'(player_col);

    // Columns past the right edge would alias onto the next row
    assign on_map  = (player_row < bomb_pkg::pos_y_t'(bomb_pkg::NUM_ROW))
                  && (player_col < bomb_pkg::pos_x_t'(bomb_pkg::NUM_COL));
    assign on_item = (state_q == bomb_pkg::ITEM_LIVE) && on_map
                  && (bomb_pkg::map_addr_t'(player_tile) == addr_q);

    // Idle slot, freed block and a lucky draw
    assign spawn = (state_q == bomb_pkg::ITEM_IDLE) && wr.we
                && (wr.data == bomb_pkg::TILE_EMPTY)
                && (rand_val <= probability);

    // ------------------------------------------------------------------
    // Slot FSM with lifetime countdown
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= bomb_pkg::ITEM_IDLE;
            life_q  <= '0;
            pickup  <= 1'b0;
        end else begin
            pickup <= 1'b0;  // Pulse by default
            case (state_q)
                bomb_pkg::ITEM_IDLE: begin
                    if (spawn) begin
                        state_q <= bomb_pkg::ITEM_LIVE;
                        life_q  <= LIFE_W'(ITEM_TIME);  // Full lifetime
                    end
                end
                bomb_pkg::ITEM_LIVE: begin
                    if (on_item) begin              // Pickup wins over expiry
                        pickup  <= 1'b1;
                        state_q <= bomb_pkg::ITEM_IDLE;
                    end else if (tick) begin
                        if (life_q == LIFE_W'(1)) begin
                            state_q <= bomb_pkg::ITEM_IDLE;  // Last tick consumed
                        end
                        life_q <= life_q - LIFE_W'(1);
                    end
                end
                default: begin
                    state_q <= bomb_pkg::ITEM_IDLE;
                end
            endcase
        end
    end

    // Address captured on spawn only
    always_ff @(posedge clk) begin
        if (spawn) begin
            addr_q <= wr.addr;
        end
    end

    assign status.active = (state_q == bomb_pkg::ITEM_LIVE);
    assign status.addr   = addr_q;

endmodule

// ==== verilog/lfsr_rand.sv ====
`timescale 1ns/1ps

module lfsr_rand (
    input  logic                clk,
    input  logic                rst,
    output bomb_pkg::prob_t     rand_val
);

    // Taps 32, 22, 2, 1 in right-shift Galois form
    localparam bomb_pkg::prob_t TAP_MASK = 32'h8020_0003;
    localparam bomb_pkg::prob_t SEED     = 32'hACE1_2468;  // Any nonzero value

    bomb_pkg::prob_t lfsr_q;

    // ------------------------------------------------------------------
    // Free-running shift, one step per cycle
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= SEED;
        end else if (lfsr_q[0]) begin
            lfsr_q <= {1'b0, lfsr_q[31:1]} ^ TAP_MASK;  // Feedback bit set
        end else begin
            lfsr_q <= {1'b0, lfsr_q[31:1]};
        end
    end

    assign rand_val = lfsr_q;  // Maximal length, never reaches zero

endmodule

// ==== verilog/bomb_pkg.sv ====
package bomb_pkg;

    // ------------------------------------------------------------------
    // Map geometry
    // ------------------------------------------------------------------
    localparam int NUM_ROW   = 11;                  // Tiles per column
    localparam int NUM_COL   = 19;                  // Tiles per row
    localparam int MAP_DEPTH = NUM_ROW * NUM_COL;   // 209 tiles
    localparam int NUM_ITEMS = 3;                   // Item slots
    localparam int ADDR_W    = $clog2(MAP_DEPTH);   // 8 bit tile address

    typedef logic [ADDR_W-1:0] map_addr_t;          // row * NUM_COL + col
    typedef logic [1:0]        map_data_t;          // Tile code
    typedef logic [10:0]       pos_x_t;             // Player pixel x
    typedef logic [9:0]        pos_y_t;             // Player pixel y
    typedef logic [31:0]       prob_t;              // Spawn threshold / draw

    // Statistic field widths
    typedef logic [3:0] bombs_t;
    typedef logic [5:0] speed_t;
    typedef logic [3:0] range_t;

    typedef enum logic [1:0] {
        TILE_EMPTY = 2'd0,
        TILE_WALL  = 2'd1,
        TILE_BRICK = 2'd2,
        TILE_EXIT  = 2'd3
    } tile_t;

    // Slot index, also selects the statistic a pickup raises
    typedef enum logic [1:0] {
        ITEM_SPEED = 2'd0,
        ITEM_BOMB  = 2'd1,
        ITEM_RANGE = 2'd2
    } item_kind_t;

    typedef enum logic [1:0] {
        ITEM_IDLE = 2'd0,
        ITEM_LIVE = 2'd1
    } item_state_t;

    // ------------------------------------------------------------------
    // Shared structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic      we;      // One-cycle strobe
        map_addr_t addr;
        map_data_t data;
    } map_write_t;          // 11 bits

    typedef struct packed {
        pos_x_t x;
        pos_y_t y;
    } player_pos_t;         // 21 bits

    typedef struct packed {
        logic      active;
        map_addr_t addr;
    } item_status_t;        // 9 bits

    typedef struct packed {
        bombs_t max_bombs;
        speed_t speed;
        range_t range;
    } player_stats_t;       // 14 bits

    // Reset values and caps
    localparam bombs_t STAT_BOMBS_INIT = 4'd1;
    localparam speed_t STAT_SPEED_INIT = 6'd4;
    localparam range_t STAT_RANGE_INIT = 4'd1;
    localparam speed_t SPEED_STEP      = 6'd4;
    localparam speed_t SPEED_LIMIT     = 6'd25;  // Last step lands on 28
    localparam bombs_t BOMBS_LIMIT     = 4'd9;
    localparam range_t RANGE_LIMIT     = 4'd9;

endpackage
